// ==== build.f ====
+incdir+dv
hw/wb_pkg.sv
hw/excp_prio.sv
hw/wb_stage.sv
hw/excp_csr.sv
hw/regfile.sv
hw/wb_commit_top.sv
dv/wb_commit_tb.sv

// ==== Bender.yml ====
package:
  name: wb_commit

sources:
  # package first, then leaf modules, then the top
  - files:
      - hw/wb_pkg.sv
      - hw/excp_prio.sv
      - hw/wb_stage.sv
      - hw/excp_csr.sv
      - hw/regfile.sv
      - hw/wb_commit_top.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/wb_commit_tb.sv

// ==== dv/wb_commit_vectors.svh ====
`ifndef WB_COMMIT_VECTORS_SVH
`define WB_COMMIT_VECTORS_SVH

// readback kinds
localparam logic [1:0] RD_NONE = 2'd0;
localparam logic [1:0] RD_RF   = 2'd1;
localparam logic [1:0] RD_CSR  = 2'd2;
// regfile entry expected to hold the row's data word
localparam logic [1:0] RD_DATA = 2'd3;

localparam logic [31:0] FULL    = 32'hffff_ffff;
localparam excp_in_t    NO_EXCP = '0;
localparam csr_wr_t     NO_CSR  = '0;
localparam excp_info_t  NO_INFO = '0;

// ctl   {left_valid, right_ready, icache_busy, soft_int}
// flags {left_ready, right_valid, stall, excp_flush, ertn_flush}
// strb  {inv, wr, rd, fill, srch, hazard}
// info  {ecode, esubcode, badv, badv_valid, excp_tlb, excp_tlbrefill}
// excp  {ertn, excp_num, ms_excp}, csr {we, num, wdata}, wr {wreg_en, wreg_index}
task automatic load_table();
    // plain commits and back-pressure
    add_row("commit_r5", 4'b1100, 32'h1c00_0000, 32'h0, {1'b1, 5'd5}, 5'h00, 2'b00,
            NO_EXCP, NO_CSR, 5'b11000, NO_INFO, 6'h00, RD_DATA, 14'd5, FULL, 32'h0);
    add_row("commit_r0", 4'b1100, 32'h1c00_0004, 32'h0, {1'b1, 5'd0}, 5'h00, 2'b00,
            NO_EXCP, NO_CSR, 5'b11000, NO_INFO, 6'h00, RD_RF, 14'd0, FULL, 32'h0);
    add_row("backpressure", 4'b1000, 32'h1c00_0008, 32'h0, {1'b1, 5'd7}, 5'h00, 2'b00,
            NO_EXCP, NO_CSR, 5'b01000, NO_INFO, 6'h00, RD_RF, 14'd7, FULL, 32'h0);
    // several bits set, lowest index wins
    add_row("prio_adef_ale", 4'b1100, 32'h1c00_0104, 32'h0000_0a03, {1'b1, 5'd9}, 5'h00,
            2'b00, {1'b0, 16'h0202, 1'b1}, NO_CSR, 5'b11010,
            {6'h08, 9'd0, 32'h1c00_0104, 3'b100}, 6'h00, RD_CSR, CSR_ERA, FULL, 32'h1c00_0104);
    add_row("prio_tlbr_data", 4'b1100, 32'h1c00_0108, 32'h8000_1000, {1'b1, 5'd9}, 5'h00,
            2'b00, {1'b0, 16'ha800, 1'b1}, NO_CSR, 5'b11010,
            {6'h3f, 9'd0, 32'h8000_1000, 3'b111}, 6'h00, RD_CSR, CSR_ESTAT, FULL, 32'h003f_0000);
    add_row("prio_pif_ppi", 4'b1100, 32'h1c00_010c, 32'h8000_2000, {1'b1, 5'd9}, 5'h00,
            2'b00, {1'b0, 16'h2008, 1'b1}, NO_CSR, 5'b11010,
            {6'h03, 9'd0, 32'h1c00_010c, 3'b110}, 6'h00, RD_CSR, CSR_BADV, FULL, 32'h1c00_010c);
    add_row("prio_adem_pme", 4'b1100, 32'h1c00_0110, 32'h9000_0004, {1'b1, 5'd9}, 5'h00,
            2'b00, {1'b0, 16'h1400, 1'b1}, NO_CSR, 5'b11010,
            {6'h08, 9'd1, 32'h9000_0004, 3'b100}, 6'h00, RD_CSR, CSR_ESTAT, FULL, 32'h0048_0000);
    // syscall carries no address, badv keeps the adem one
    add_row("prio_sys_ale", 4'b1100, 32'h1c00_0114, 32'h9000_0008, {1'b1, 5'd9}, 5'h00,
            2'b00, {1'b0, 16'h0220, 1'b1}, NO_CSR, 5'b11010,
            {6'h0b, 9'd0, 32'h0, 3'b000}, 6'h00, RD_CSR, CSR_BADV, FULL, 32'h9000_0004);
    add_row("excp_no_rf_write", 4'b0000, 32'h0, 32'h0, {1'b0, 5'd0}, 5'h00, 2'b00,
            NO_EXCP, NO_CSR, 5'b00000, NO_INFO, 6'h00, RD_RF, 14'd9, FULL, 32'h0);
    // icache busy holds the flush back
    add_row("icache_stall", 4'b1110, 32'h1c00_0118, 32'h0, {1'b0, 5'd0}, 5'h00, 2'b00,
            {1'b0, 16'h0080, 1'b1}, NO_CSR, 5'b00100, {6'h0d, 9'd0, 32'h0, 3'b000},
            6'h00, RD_CSR, CSR_ESTAT, FULL, 32'h000b_0000);
    add_row("icache_release", 4'b1100, 32'h1c00_0118, 32'h0, {1'b0, 5'd0}, 5'h00, 2'b00,
            {1'b0, 16'h0080, 1'b1}, NO_CSR, 5'b11010, {6'h0d, 9'd0, 32'h0, 3'b000},
            6'h00, RD_CSR, CSR_ESTAT, FULL, 32'h000d_0000);
    // prmd write then return
    add_row("csr_write_prmd", 4'b1100, 32'h1c00_0200, 32'h0, {1'b0, 5'd0}, 5'h00, 2'b00,
            NO_EXCP, {1'b1, CSR_PRMD, 32'h7}, 5'b11000, NO_INFO, 6'h00,
            RD_CSR, CSR_PRMD, FULL, 32'h7);
    add_row("ertn", 4'b1100, 32'h1c00_0204, 32'h0, {1'b0, 5'd0}, 5'h00, 2'b00,
            {1'b1, 16'h0000, 1'b0}, NO_CSR, 5'b11001, NO_INFO, 6'h00,
            RD_CSR, CSR_CRMD, 32'h7, 32'h7);
    add_row("ertn_with_brk", 4'b1100, 32'h1c00_0208, 32'h0, {1'b0, 5'd0}, 5'h00, 2'b00,
            {1'b1, 16'h0040, 1'b1}, NO_CSR, 5'b11010, {6'h0c, 9'd0, 32'h0, 3'b000},
            6'h00, RD_CSR, CSR_CRMD, 32'h7, 32'h0);
    // tlb strobes, hazard for srch and rd
    add_row("tlb_srch", 4'b1100, 32'h1c00_0300, 32'h0, {1'b0, 5'd0}, 5'b10000, 2'b00,
            NO_EXCP, NO_CSR, 5'b11000, NO_INFO, 6'b000011, RD_NONE, 14'd0, FULL, 32'h0);
    add_row("tlb_rd", 4'b1100, 32'h1c00_0304, 32'h0, {1'b0, 5'd0}, 5'b00100, 2'b00,
            NO_EXCP, NO_CSR, 5'b11000, NO_INFO, 6'b001001, RD_NONE, 14'd0, FULL, 32'h0);
    add_row("tlb_inv_wr_fill", 4'b1100, 32'h1c00_0308, 32'h0, {1'b0, 5'd0}, 5'b01011, 2'b00,
            NO_EXCP, NO_CSR, 5'b11000, NO_INFO, 6'b110100, RD_NONE, 14'd0, FULL, 32'h0);
    add_row("tlb_no_valid", 4'b0100, 32'h1c00_030c, 32'h0, {1'b0, 5'd0}, 5'b11111, 2'b00,
            NO_EXCP, NO_CSR, 5'b10000, NO_INFO, 6'b000000, RD_NONE, 14'd0, FULL, 32'h0);
    // ll bit, blocked by an exception
    add_row("llbit_set", 4'b1100, 32'h1c00_0400, 32'h0, {1'b0, 5'd0}, 5'h00, 2'b11,
            NO_EXCP, NO_CSR, 5'b11000, NO_INFO, 6'h00, RD_CSR, CSR_LLBCTL, FULL, 32'h1);
    add_row("llbit_excp", 4'b1100, 32'h1c00_0404, 32'h9000_0011, {1'b0, 5'd0}, 5'h00,
            2'b10, {1'b0, 16'h0200, 1'b1}, NO_CSR, 5'b11010,
            {6'h09, 9'd0, 32'h9000_0011, 3'b100}, 6'h00, RD_CSR, CSR_LLBCTL, FULL, 32'h1);
    // soft interrupt not built in
    add_row("soft_int_off", 4'b1101, 32'h1c00_0500, 32'h0, {1'b1, 5'd12}, 5'h00, 2'b00,
            NO_EXCP, NO_CSR, 5'b11000, NO_INFO, 6'h00, RD_DATA, 14'd12, FULL, 32'h0);
endtask

`endif

// ==== dv/wb_commit_tb.sv ====
`default_nettype none

module wb_commit_tb;
    import wb_pkg::*;

    // one packet with its expected responses
    typedef struct {
        string       name;
        logic [3:0]  ctl;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [5:0]  wr;
        logic [4:0]  tlb_op;
        logic [1:0]  ll;
        excp_in_t    excp;
        csr_wr_t     csr;
        logic [4:0]  flags;
        excp_info_t  info;
        logic [5:0]  strb;
        logic [1:0]  rd_kind;
        logic [13:0] rd_addr;
        logic [31:0] rd_mask;
        logic [31:0] rd_exp;
    } row_t;

    localparam int READY_TIMEOUT = 20;

    logic        clk;
    logic        rst;
    logic        left_valid;
    logic        left_ready;
    logic        right_valid;
    logic        right_ready;
    logic        icache_busy;
    logic        soft_int;
    mem_ctrl_t   mem_ctrl;
    excp_in_t    excp_in;
    csr_wr_t     csr_wr;
    logic [4:0]  rf_raddr;
    logic [13:0] csr_rd_num;
    logic        stall;
    logic        excp_flush;
    logic        ertn_flush;
    excp_info_t  excp_info;
    logic [31:0] excp_era;
    tlb_cmd_t    tlb_cmd;
    logic [31:0] rf_rdata;
    logic [31:0] csr_rd_data;

    row_t        rows[$];
    integer      seed;
    logic [31:0] cur_data;

    `include "wb_commit_vectors.svh"

    wb_commit_top #(
        .SOFT_INT_EN (1'b0)
    ) wb_commit_i (
        .clk         (clk),
        .rst         (rst),
        .left_valid  (left_valid),
        .left_ready  (left_ready),
        .right_valid (right_valid),
        .right_ready (right_ready),
        .icache_busy (icache_busy),
        .soft_int    (soft_int),
        .mem_ctrl    (mem_ctrl),
        .excp_in     (excp_in),
        .csr_wr      (csr_wr),
        .rf_raddr    (rf_raddr),
        .csr_rd_num  (csr_rd_num),
        .stall       (stall),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .excp_info   (excp_info),
        .excp_era    (excp_era),
        .tlb_cmd     (tlb_cmd),
        .rf_rdata    (rf_rdata),
        .csr_rd_data (csr_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2;
            clk = ~clk;
        end
    end

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_val(input string name, input string field,
                             input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp)
        else begin
            $display("FAIL %s %s expected %h actual %h", name, field, exp, got);
            stop_on_error();
        end
    endtask

    task automatic add_row(input string name, input logic [3:0] ctl, input logic [31:0] pc,
                           input logic [31:0] addr, input logic [5:0] wr,
                           input logic [4:0] tlb_op, input logic [1:0] ll,
                           input excp_in_t excp, input csr_wr_t csr, input logic [4:0] flags,
                           input excp_info_t info, input logic [5:0] strb,
                           input logic [1:0] rd_kind, input logic [13:0] rd_addr,
                           input logic [31:0] rd_mask, input logic [31:0] rd_exp);
        rows.push_back('{name, ctl, pc, addr, wr, tlb_op, ll, excp, csr, flags, info, strb,
                         rd_kind, rd_addr, rd_mask, rd_exp});
    endtask

    // bus quiet, no packet offered
    task automatic drive_idle();
        left_valid  = 1'b0;
        right_ready = 1'b0;
        icache_busy = 1'b0;
        soft_int    = 1'b0;
        mem_ctrl    = '0;
        excp_in     = '0;
        csr_wr      = '0;
    endtask

    task automatic apply_row(input row_t r);
        {left_valid, right_ready, icache_busy, soft_int} = r.ctl;
        // fresh data word per packet
        cur_data                = $random(seed);
        mem_ctrl                = '0;
        mem_ctrl.pc             = r.pc;
        mem_ctrl.mem_addr       = r.addr;
        mem_ctrl.mem_result     = cur_data;
        mem_ctrl.wreg_en        = r.wr[5];
        mem_ctrl.wreg_index     = r.wr[4:0];
        mem_ctrl.tlb_op         = r.tlb_op;
        mem_ctrl.llbit_set_en   = r.ll[1];
        mem_ctrl.llbit_value    = r.ll[0];
        mem_ctrl.data_tlbindex  = cur_data[4:0];
        mem_ctrl.data_tlbfound  = cur_data[5];
        excp_in                 = r.excp;
        csr_wr                  = r.csr;
    endtask

    // zero-delay outputs, sampled mid low phase
    task automatic check_outputs(input row_t r);
        check_val(r.name, "flags", r.flags,
                  {left_ready, right_valid, stall, excp_flush, ertn_flush});
        check_val(r.name, "excp_info", r.info, excp_info);
        check_val(r.name, "excp_era", r.pc, excp_era);
        check_val(r.name, "tlb strobes", r.strb,
                  {tlb_cmd.inv_en, tlb_cmd.wr_en, tlb_cmd.rd_en, tlb_cmd.fill_en,
                   tlb_cmd.srch_en, tlb_cmd.hazard});
        // index and found pass straight through
        check_val(r.name, "tlb index", {mem_ctrl.data_tlbfound, mem_ctrl.data_tlbindex},
                  {tlb_cmd.tlbfound, tlb_cmd.tlbindex});
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (!left_ready && (n < READY_TIMEOUT)) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!left_ready) begin
            $display("timeout waiting for left_ready in %s", name);
            stop_on_error();
        end
    endtask

    task automatic check_readback(input row_t r);
        logic [31:0] exp;
        logic [31:0] got;
        exp = (r.rd_kind == RD_DATA) ? cur_data : r.rd_exp;
        if (r.rd_kind == RD_CSR) begin
            csr_rd_num = r.rd_addr;
        end else begin
            rf_raddr = r.rd_addr[4:0];
        end
        #1;
        got = (r.rd_kind == RD_CSR) ? csr_rd_data : rf_rdata;
        if (r.rd_kind != RD_NONE) begin
            check_val(r.name, "readback", exp & r.rd_mask, got & r.rd_mask);
        end
    endtask

    initial begin
        seed       = 14;
        rst        = 1'b1;
        rf_raddr   = 5'd0;
        csr_rd_num = CSR_CRMD;
        drive_idle();
        load_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        // reset state, da set and everything quiet
        check_val("after_reset", "crmd", 64'h8, csr_rd_data);
        check_val("after_reset", "flags", 64'h0,
                  {left_ready, right_valid, stall, excp_flush, ertn_flush});
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            apply_row(rows[i]);
            #1;
            // offered and expected to be taken
            if (rows[i].ctl[3] && rows[i].flags[4]) begin
                wait_ready(rows[i].name);
            end
            check_outputs(rows[i]);
            @(posedge clk);
            @(negedge clk);
            drive_idle();
            check_readback(rows[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/wb_commit_top.sv ====
`default_nettype none

module wb_commit_top #(
    parameter bit SOFT_INT_EN = 1'b0
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    left_valid,
    output logic                   left_ready,
    output logic                   right_valid,
    input  wire                    right_ready,
    input  wire                    icache_busy,
    input  wire                    soft_int,
    input  wire wb_pkg::mem_ctrl_t mem_ctrl,
    input  wire wb_pkg::excp_in_t  excp_in,
    input  wire wb_pkg::csr_wr_t   csr_wr,
    input  wire [4:0]              rf_raddr,
    input  wire [13:0]             csr_rd_num,
    output logic                   stall,
    output logic                   excp_flush,
    output logic                   ertn_flush,
    output wb_pkg::excp_info_t     excp_info,
    output logic [31:0]            excp_era,
    output wb_pkg::tlb_cmd_t       tlb_cmd,
    output logic [31:0]            rf_rdata,
    output logic [31:0]            csr_rd_data
);
    import wb_pkg::*;

    logic        accept;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    csr_wr_t     csr_commit;
    logic        llbit_we;
    logic        llbit_value;

    // packet taken this edge
    assign accept = left_valid && left_ready;

    wb_stage #(
        .SOFT_INT_EN (SOFT_INT_EN)
    ) stage_i (
        .clk         (clk),
        .rst         (rst),
        .left_valid  (left_valid),
        .left_ready  (left_ready),
        .right_valid (right_valid),
        .right_ready (right_ready),
        .icache_busy (icache_busy),
        .soft_int    (soft_int),
        .mem_ctrl    (mem_ctrl),
        .excp_in     (excp_in),
        .csr_wr      (csr_wr),
        .stall       (stall),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .excp_info   (excp_info),
        .excp_era    (excp_era),
        .tlb_cmd     (tlb_cmd),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .csr_commit  (csr_commit),
        .llbit_we    (llbit_we),
        .llbit_value (llbit_value)
    );

    excp_csr csr_i (
        .clk         (clk),
        .rst         (rst),
        .flush_excp  (excp_flush),
        .flush_ertn  (ertn_flush),
        .accept      (accept),
        .excp_info   (excp_info),
        .era         (excp_era),
        .csr_commit  (csr_commit),
        .llbit_we    (llbit_we),
        .llbit_value (llbit_value),
        .csr_rd_num  (csr_rd_num),
        .csr_rd_data (csr_rd_data)
    );

    regfile rf_i (
        .clk   (clk),
        .rst   (rst),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`default_nettype none

module regfile (
    input  wire         clk,
    input  wire         rst,
    input  wire         we,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata,
    input  wire  [4:0]  raddr,
    output logic [31:0] rdata
);
    logic [31:0] regs [32];

    // single commit port, r0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, r0 hardwired
    assign rdata = (raddr == 5'd0) ? 32'd0 : regs[raddr];

endmodule

`default_nettype wire

// ==== hw/excp_csr.sv ====
`default_nettype none

module excp_csr (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush_excp,
    input  wire                     flush_ertn,
    input  wire                     accept,
    input  wire wb_pkg::excp_info_t excp_info,
    input  wire [31:0]              era,
    input  wire wb_pkg::csr_wr_t    csr_commit,
    input  wire                     llbit_we,
    input  wire                     llbit_value,
    input  wire [13:0]              csr_rd_num,
    output logic [31:0]             csr_rd_data
);
    import wb_pkg::*;

    // crmd fields
    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    // prmd fields
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    // estat fields
    logic [1:0]  estat_is;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era_q;
    logic [31:0] badv_q;
    logic        llbit;
    logic        take_excp;
    logic        take_ertn;

    // flushes only land on an accepting edge
    assign take_excp = accept && flush_excp;
    assign take_ertn = accept && flush_ertn;

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv       <= 2'd0;
            crmd_ie        <= 1'b0;
            crmd_da        <= 1'b1;
            crmd_pg        <= 1'b0;
            crmd_datf      <= 2'd0;
            crmd_datm      <= 2'd0;
            prmd_pplv      <= 2'd0;
            prmd_pie       <= 1'b0;
            estat_is       <= 2'd0;
            estat_ecode    <= 6'd0;
            estat_esubcode <= 9'd0;
            era_q          <= 32'd0;
            badv_q         <= 32'd0;
            llbit          <= 1'b0;
        end else if (take_excp) begin
            // save mode, drop to kernel with ints off
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            crmd_plv       <= 2'd0;
            crmd_ie        <= 1'b0;
            // refill handler runs untranslated
            if (excp_info.excp_tlbrefill) begin
                crmd_da <= 1'b1;
                crmd_pg <= 1'b0;
            end
            era_q          <= era;
            estat_ecode    <= excp_info.ecode;
            estat_esubcode <= excp_info.esubcode;
            if (excp_info.badv_valid) begin
                badv_q <= excp_info.badv;
            end
        end else begin
            if (take_ertn) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
                // leaving refill, back to paging
                if (estat_ecode == ECODE_TLBR) begin
                    crmd_da <= 1'b0;
                    crmd_pg <= 1'b1;
                end
            end
            if (csr_commit.we) begin
                case (csr_commit.num)
                    CSR_CRMD: begin
                        crmd_plv  <= csr_commit.wdata[1:0];
                        crmd_ie   <= csr_commit.wdata[2];
                        crmd_da   <= csr_commit.wdata[3];
                        crmd_pg   <= csr_commit.wdata[4];
                        crmd_datf <= csr_commit.wdata[6:5];
                        crmd_datm <= csr_commit.wdata[8:7];
                    end
                    CSR_PRMD: begin
                        prmd_pplv <= csr_commit.wdata[1:0];
                        prmd_pie  <= csr_commit.wdata[2];
                    end
                    // only the soft int bits are writable
                    CSR_ESTAT: estat_is <= csr_commit.wdata[1:0];
                    CSR_ERA:   era_q    <= csr_commit.wdata;
                    CSR_BADV:  badv_q   <= csr_commit.wdata;
                    // wcllb clears the ll bit
                    CSR_LLBCTL: begin
                        if (csr_commit.wdata[1]) begin
                            llbit <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            // ll/sc update wins over wcllb
            if (llbit_we) begin
                llbit <= llbit_value;
            end
        end
    end

    always_comb begin
        case (csr_rd_num)
            CSR_CRMD:   csr_rd_data = {23'd0, crmd_datm, crmd_datf, crmd_pg, crmd_da,
                                       crmd_ie, crmd_plv};
            CSR_PRMD:   csr_rd_data = {29'd0, prmd_pie, prmd_pplv};
            CSR_ESTAT:  csr_rd_data = {1'b0, estat_esubcode, estat_ecode, 14'd0, estat_is};
            CSR_ERA:    csr_rd_data = era_q;
            CSR_BADV:   csr_rd_data = badv_q;
            CSR_LLBCTL: csr_rd_data = {31'd0, llbit};
            default:    csr_rd_data = 32'd0;
        endcase
    end

    // stage must not send a csr write with a flush
    assert property (@(posedge clk) disable iff (rst)
        (accept && (flush_excp || flush_ertn)) |-> !csr_commit.we)
        else $error("excp_csr: csr write together with a flush");

endmodule

`default_nettype wire

// ==== hw/wb_stage.sv ====
`default_nettype none

module wb_stage #(
    parameter bit SOFT_INT_EN = 1'b0
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   left_valid,
    output logic                  left_ready,
    output logic                  right_valid,
    input  wire                   right_ready,
    input  wire                   icache_busy,
    input  wire                   soft_int,
    input  wire wb_pkg::mem_ctrl_t mem_ctrl,
    input  wire wb_pkg::excp_in_t  excp_in,
    input  wire wb_pkg::csr_wr_t   csr_wr,
    output logic                  stall,
    output logic                  excp_flush,
    output logic                  ertn_flush,
    output wb_pkg::excp_info_t    excp_info,
    output logic [31:0]           excp_era,
    output wb_pkg::tlb_cmd_t      tlb_cmd,
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [31:0]           rf_wdata,
    output wb_pkg::csr_wr_t       csr_commit,
    output logic                  llbit_we,
    output logic                  llbit_value
);
    logic soft_int_on;
    logic excp_pend;
    logic accept;

    // soft interrupt only counts when built in
    assign soft_int_on = SOFT_INT_EN && soft_int;
    assign excp_pend   = excp_in.ms_excp || soft_int_on;

    // hold flushes off while the icache is mid-refill
    assign stall = left_valid && icache_busy && (excp_pend || excp_in.ertn);

    // pass-through handshake, broken only by a stall
    assign left_ready  = stall ? 1'b0 : right_ready;
    assign right_valid = stall ? 1'b0 : left_valid;
    assign accept      = left_valid && left_ready;

    assign excp_flush = left_valid && excp_pend && !icache_busy;
    // any exception beats ertn
    assign ertn_flush = left_valid && excp_in.ertn && !icache_busy && !excp_pend;

    excp_prio prio_i (
        .excp_vec   (excp_in.excp_num),
        .soft_int   (soft_int_on),
        .pc         (mem_ctrl.pc),
        .mem_addr   (mem_ctrl.mem_addr),
        .left_valid (left_valid),
        .info       (excp_info)
    );

    assign excp_era = mem_ctrl.pc;

    // tlb strobes follow left_valid only
    always_comb begin
        tlb_cmd          = '0;
        tlb_cmd.inv_en   = mem_ctrl.tlb_op[0] && left_valid;
        tlb_cmd.wr_en    = mem_ctrl.tlb_op[1] && left_valid;
        tlb_cmd.rd_en    = mem_ctrl.tlb_op[2] && left_valid;
        tlb_cmd.fill_en  = mem_ctrl.tlb_op[3] && left_valid;
        tlb_cmd.srch_en  = mem_ctrl.tlb_op[4] && left_valid;
        tlb_cmd.tlbindex = mem_ctrl.data_tlbindex;
        tlb_cmd.tlbfound = mem_ctrl.data_tlbfound;
        tlb_cmd.hazard   = (mem_ctrl.tlb_op[4] || mem_ctrl.tlb_op[2]) && left_valid;
    end

    // gpr commit, killed by a taken exception
    assign rf_we    = accept && mem_ctrl.wreg_en && !excp_flush;
    assign rf_waddr = mem_ctrl.wreg_index;
    assign rf_wdata = mem_ctrl.mem_result;

    // csr write only from a clean accepted packet
    always_comb begin
        csr_commit    = csr_wr;
        csr_commit.we = csr_wr.we && accept && !excp_pend;
    end

    assign llbit_we    = mem_ctrl.llbit_set_en && accept && !excp_pend;
    assign llbit_value = mem_ctrl.llbit_value;

    // the two flushes are exclusive
    assert property (@(posedge clk) disable iff (rst)
        !(excp_flush && ertn_flush))
        else $error("wb_stage: excp_flush and ertn_flush together");

    // stalled packet must not be taken
    assert property (@(posedge clk) disable iff (rst)
        stall |-> !left_ready && !right_valid)
        else $error("wb_stage: handshake open during stall");

endmodule

`default_nettype wire

// ==== hw/excp_prio.sv ====
`default_nettype none

module excp_prio (
    input  wire [15:0]          excp_vec,
    input  wire                 soft_int,
    input  wire [31:0]          pc,
    input  wire [31:0]          mem_addr,
    input  wire                 left_valid,
    output wb_pkg::excp_info_t  info
);
    import wb_pkg::*;

    logic [15:0] vec;
    logic [3:0]  sel;
    logic        hit;
    logic        fetch_grp;
    logic        mem_grp;

    // soft interrupt lands in the int slot
    assign vec = {excp_vec[15:1], excp_vec[0] | soft_int};

    // lowest set bit wins, scan downwards
    always_comb begin
        sel = 4'd0;
        hit = 1'b0;
        for (int i = 15; i >= 0; i--) begin
            if (vec[i]) begin
                sel = 4'(i);
                hit = 1'b1;
            end
        end
    end

    // fetch side faults carry the pc
    assign fetch_grp = hit && (sel >= 4'd1) && (sel <= 4'd4);
    // ale onwards carry the data address
    assign mem_grp = hit && (sel >= 4'd9);

    always_comb begin
        info = '0;
        if (hit) begin
            case (sel)
                4'd0: info.ecode = ECODE_INT;
                4'd1: info.ecode = ECODE_ADEF;
                4'd2: info.ecode = ECODE_TLBR;
                4'd3: info.ecode = ECODE_PIF;
                4'd4: info.ecode = ECODE_PPI;
                4'd5: info.ecode = ECODE_SYS;
                4'd6: info.ecode = ECODE_BRK;
                4'd7: info.ecode = ECODE_INE;
                4'd8: info.ecode = ECODE_IPE;
                4'd9: info.ecode = ECODE_ALE;
                4'd10: begin
                    info.ecode    = ECODE_ADEM;
                    info.esubcode = ESUBCODE_ADEM;
                end
                4'd11: info.ecode = ECODE_TLBR;
                4'd12: info.ecode = ECODE_PME;
                4'd13: info.ecode = ECODE_PPI;
                4'd14: info.ecode = ECODE_PIS;
                default: info.ecode = ECODE_PIL;
            endcase
            // inst tlb kinds 2..4, data tlb kinds 11..15
            info.excp_tlb = left_valid && (((sel >= 4'd2) && (sel <= 4'd4)) || (sel >= 4'd11));
            // only the refill pair switches to direct mapping
            info.excp_tlbrefill = left_valid && ((sel == 4'd2) || (sel == 4'd11));
            info.badv_valid = left_valid && (fetch_grp || mem_grp);
            if (fetch_grp) begin
                info.badv = pc;
            end else if (mem_grp) begin
                info.badv = mem_addr;
            end
        end
    end

    // a bad address needs a real fault behind it
    always_comb begin
        assert final (!info.badv_valid || (excp_vec != 16'd0))
            else $error("excp_prio: badv_valid with empty exception vector");
    end

endmodule

`default_nettype wire

// ==== hw/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // packet handed over by the memory stage
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] mem_addr;
        logic [31:0] mem_result;
        logic        wreg_en;
        logic [4:0]  wreg_index;
        // 0 invtlb, 1 tlbwr, 2 tlbrd, 3 tlbfill, 4 tlbsrch
        logic [4:0]  tlb_op;
        logic        llbit_set_en;
        logic        llbit_value;
        // tlbsrch result carried down from mem
        logic [4:0]  data_tlbindex;
        logic        data_tlbfound;
    } mem_ctrl_t;

    // exception vector, bit 0 highest priority
    typedef struct packed {
        logic        ertn;
        logic [15:0] excp_num;
        logic        ms_excp;
    } excp_in_t;

    typedef struct packed {
        logic        we;
        logic [13:0] num;
        logic [31:0] wdata;
    } csr_wr_t;

    // sorted exception, feeds the csr block
    typedef struct packed {
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
        logic        badv_valid;
        logic        excp_tlb;
        logic        excp_tlbrefill;
    } excp_info_t;

    typedef struct packed {
        logic       inv_en;
        logic       wr_en;
        logic       rd_en;
        logic       fill_en;
        logic       srch_en;
        logic [4:0] tlbindex;
        logic       tlbfound;
        // tlbrd/tlbsrch touch csrs read by later stages
        logic       hazard;
    } tlb_cmd_t;

    // loongarch ecodes
    localparam logic [5:0] ECODE_INT  = 6'h00;
    localparam logic [5:0] ECODE_PIL  = 6'h01;
    localparam logic [5:0] ECODE_PIS  = 6'h02;
    localparam logic [5:0] ECODE_PIF  = 6'h03;
    localparam logic [5:0] ECODE_PME  = 6'h04;
    localparam logic [5:0] ECODE_PPI  = 6'h07;
    localparam logic [5:0] ECODE_ADEF = 6'h08;
    localparam logic [5:0] ECODE_ADEM = 6'h08;
    localparam logic [5:0] ECODE_ALE  = 6'h09;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;
    localparam logic [5:0] ECODE_IPE  = 6'h0e;
    localparam logic [5:0] ECODE_TLBR = 6'h3f;

    // adef shares the ecode with subcode 0
    localparam logic [8:0] ESUBCODE_ADEM = 9'd1;

    // csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_LLBCTL = 14'h060;

endpackage

`default_nettype wire
